// File: hw/execPkg.sv
// Execute stage shared types: opcodes, exception codes and handshake payloads
package execPkg;

    typedef enum logic
    {
        UNIT_ALU = 1'b0,
        UNIT_MDU = 1'b1
    } unitE;

    typedef enum logic [3:0]
    {
        ALU_ADD  = 4'd0,  // Traps on overflow
        ALU_ADDU = 4'd1,
        ALU_SUB  = 4'd2,  // Traps on overflow
        ALU_SUBU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_NOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11,
        ALU_SLT  = 4'd12,
        ALU_SLTU = 4'd13,
        ALU_CLO  = 4'd14,
        ALU_CLZ  = 4'd15
    } aluOpE;

    typedef enum logic [2:0]
    {
        MD_MULT  = 3'd0,
        MD_MULTU = 3'd1,
        MD_DIV   = 3'd2,
        MD_DIVU  = 3'd3,
        MD_MFHI  = 3'd4,
        MD_MFLO  = 3'd5,
        MD_MTHI  = 3'd6,
        MD_MTLO  = 3'd7
    } mdOpE;

    typedef enum logic [4:0]
    {
        EXC_NONE = 5'd0,
        EXC_OV   = 5'd12  // Arithmetic overflow
    } excCodeE;

    typedef logic [3:0] tagT;

    typedef struct packed {
        unitE        unit;
        aluOpE       aluOp;
        mdOpE        mdOp;
        tagT         tag;
        logic [31:0] srcA;  // Shift amount source for shifts
        logic [31:0] srcB;
    } execReqT;

    typedef struct packed {
        tagT         tag;
        logic [31:0] result;
        logic        zero;
        logic        excOccur;
        excCodeE     excCode;
    } execRespT;

    typedef struct packed {
        logic [31:0] result;
        logic        excOccur;
        excCodeE     excCode;
    } aluOutT;

endpackage

// File: hw/aluCore.sv
// Combinational ALU with overflow trapping and leading zero/one counts
`timescale 1ns/1ps

module aluCore (
    input  execPkg::execReqT req,
    output execPkg::aluOutT  aluOut
);

    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [32:0] sumExt;
    logic [32:0] diffExt;
    logic        ovfTrap;
    logic [5:0]  zeroCount;
    logic [5:0]  oneCount;

    // Halving search over 16, 8, 4 and 2 bit windows
    function automatic logic [5:0] countLeadZeros(input logic [31:0] v);
        logic [5:0]  n;
        logic [15:0] v16;
        logic [7:0]  v8;
        logic [3:0]  v4;
        n[5] = (v == 32'h0);
        n[4] = (v[31:16] == 16'h0) && !n[5];
        v16  = n[4] ? v[15:0] : v[31:16];
        n[3] = (v16[15:8] == 8'h0) && !n[5];
        v8   = n[3] ? v16[7:0] : v16[15:8];
        n[2] = (v8[7:4] == 4'h0) && !n[5];
        v4   = n[2] ? v8[3:0] : v8[7:4];
        n[1] = (v4[3:2] == 2'b00) && !n[5];
        n[0] = n[1] ? (!v4[1] && !n[5]) : (!v4[3] && !n[5]);
        return n;
    endfunction

    assign srcA = req.srcA;
    assign srcB = req.srcB;

    // One extra sign bit exposes signed overflow
    assign sumExt  = {srcA[31], srcA} + {srcB[31], srcB};
    assign diffExt = {srcA[31], srcA} - {srcB[31], srcB};

    assign zeroCount = countLeadZeros(srcA);
    assign oneCount  = countLeadZeros(~srcA);  // Leading ones are leading zeros of the inverse

    assign ovfTrap = ((req.aluOp == execPkg::ALU_ADD) && (sumExt[32] != sumExt[31])) ||
                     ((req.aluOp == execPkg::ALU_SUB) && (diffExt[32] != diffExt[31]));

    always_comb
    begin
        case (req.aluOp)
            execPkg::ALU_ADD,
            execPkg::ALU_ADDU: aluOut.result = sumExt[31:0];  // Wrapped even on trap
            execPkg::ALU_SUB,
            execPkg::ALU_SUBU: aluOut.result = diffExt[31:0];
            execPkg::ALU_AND:  aluOut.result = srcA & srcB;
            execPkg::ALU_OR:   aluOut.result = srcA | srcB;
            execPkg::ALU_XOR:  aluOut.result = srcA ^ srcB;
            execPkg::ALU_NOR:  aluOut.result = ~(srcA | srcB);
            execPkg::ALU_SLL:  aluOut.result = srcB << srcA[4:0];
            execPkg::ALU_SRL:  aluOut.result = srcB >> srcA[4:0];
            execPkg::ALU_SRA:  aluOut.result = $signed(srcB) >>> srcA[4:0];
            execPkg::ALU_LUI:  aluOut.result = {srcB[15:0], 16'h0};
            execPkg::ALU_SLT:  aluOut.result = {31'h0, $signed(srcA) < $signed(srcB)};
            execPkg::ALU_SLTU: aluOut.result = {31'h0, srcA < srcB};
            execPkg::ALU_CLO:  aluOut.result = {26'h0, oneCount};
            execPkg::ALU_CLZ:  aluOut.result = {26'h0, zeroCount};
            default:           aluOut.result = 32'h0;
        endcase

        aluOut.excOccur = ovfTrap;
        aluOut.excCode  = execPkg::EXC_NONE;
        if (ovfTrap)
        begin
            aluOut.excCode = execPkg::EXC_OV;
        end
    end

    // Trap only on ADD or SUB whose result sign breaks the operand signs
    aOvfOnlyTrapping: assert final (aluOut.excOccur ==
        ((((req.aluOp == execPkg::ALU_ADD) && (srcA[31] == srcB[31])) ||
          ((req.aluOp == execPkg::ALU_SUB) && (srcA[31] != srcB[31]))) &&
         (aluOut.result[31] != srcA[31])))
        else $error("aluCore: overflow flag wrong for aluOp %0d", req.aluOp);

endmodule

// File: hw/mulDivUnit.sv
// Multiply/divide unit owning HI/LO: pipelined multiply, restoring divide, HI/LO moves
`timescale 1ns/1ps

module mulDivUnit #(
    parameter int mulStages = 2
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             mdStart,
    input  execPkg::execReqT req,
    output logic             mdDone,
    output logic [31:0]      mdResult
);

    logic [31:0]          hi;
    logic [31:0]          lo;
    logic                 opSigned;
    logic                 mulStart;
    logic                 divStart;
    logic                 moveStart;
    logic signed [32:0]   mulA;
    logic signed [32:0]   mulB;
    logic signed [65:0]   mulFull;
    logic [63:0]          mulPipe [0:mulStages-1];
    logic [mulStages-1:0] mulValid;
    logic [31:0]          absA;
    logic [31:0]          absB;
    logic [31:0]          divRem;
    logic [31:0]          divQuo;
    logic [31:0]          divDvsr;
    logic [32:0]          divShift;
    logic [33:0]          divDiff;
    logic                 negQuo;
    logic                 negRem;
    logic                 divZero;
    logic                 divBusy;
    logic                 divDone;
    logic [4:0]           divCount;
    logic [31:0]          quoFinal;
    logic [31:0]          remFinal;
    logic                 moveDone;
    logic [31:0]          moveResult;
    logic                 mdBusy;

    if (mulStages < 1 || mulStages > 4)
    begin : gBadStages
        $fatal(1, "mulDivUnit: mulStages must be 1 to 4, got %0d", mulStages);
    end

    assign opSigned  = (req.mdOp == execPkg::MD_MULT) || (req.mdOp == execPkg::MD_DIV);
    assign mulStart  = mdStart && (req.mdOp inside {execPkg::MD_MULT, execPkg::MD_MULTU});
    assign divStart  = mdStart && (req.mdOp inside {execPkg::MD_DIV, execPkg::MD_DIVU});
    assign moveStart = mdStart && !mulStart && !divStart;

    // 33-bit operands so one signed multiplier serves both flavours
    assign mulA    = {opSigned & req.srcA[31], req.srcA};
    assign mulB    = {opSigned & req.srcB[31], req.srcB};
    assign mulFull = mulA * mulB;

    assign absA = (opSigned && req.srcA[31]) ? -req.srcA : req.srcA;
    assign absB = (opSigned && req.srcB[31]) ? -req.srcB : req.srcB;

    // One restoring step per cycle
    assign divShift = {divRem, divQuo[31]};
    assign divDiff  = {1'b0, divShift} - {2'b00, divDvsr};

    assign quoFinal = divZero ? 32'hffff_ffff : (negQuo ? -divQuo : divQuo);
    assign remFinal = negRem ? -divRem : divRem;  // Remainder follows the dividend

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            mulValid <= '0;
            moveDone <= 1'b0;
            divBusy  <= 1'b0;
            divDone  <= 1'b0;
            divCount <= '0;
        end
        else
        begin
            mulValid[0] <= mulStart;
            for (int i = 1; i < mulStages; i++)
            begin
                mulValid[i] <= mulValid[i-1];
            end
            moveDone <= moveStart;
            divDone  <= divBusy && (divCount == 5'd31);
            if (divStart)
            begin
                divBusy  <= 1'b1;
                divCount <= '0;
            end
            else if (divBusy)
            begin
                divCount <= divCount + 5'd1;
                if (divCount == 5'd31)
                begin
                    divBusy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        mulPipe[0] <= mulFull[63:0];
        for (int i = 1; i < mulStages; i++)
        begin
            mulPipe[i] <= mulPipe[i-1];
        end
    end

    always_ff @(posedge clk)
    begin
        if (divStart)
        begin
            divRem  <= '0;
            divQuo  <= absA;
            divDvsr <= absB;
            negQuo  <= opSigned && (req.srcA[31] ^ req.srcB[31]);
            negRem  <= opSigned && req.srcA[31];
            divZero <= (req.srcB == 32'h0);
        end
        else if (divBusy)
        begin
            if (!divDiff[33])
            begin
                divRem <= divDiff[31:0];
                divQuo <= {divQuo[30:0], 1'b1};
            end
            else
            begin
                divRem <= divShift[31:0];
                divQuo <= {divQuo[30:0], 1'b0};
            end
        end
    end

    // HI/LO are architectural state, written by whichever op completes
    always_ff @(posedge clk)
    begin
        if (moveStart)
        begin
            case (req.mdOp)
                execPkg::MD_MFHI: moveResult <= hi;
                execPkg::MD_MFLO: moveResult <= lo;
                default:          moveResult <= 32'h0;
            endcase
            if (req.mdOp == execPkg::MD_MTHI)
            begin
                hi <= req.srcA;
            end
            if (req.mdOp == execPkg::MD_MTLO)
            begin
                lo <= req.srcA;
            end
        end
        if (mulValid[mulStages-1])
        begin
            {hi, lo} <= mulPipe[mulStages-1];
        end
        if (divDone)
        begin
            hi <= remFinal;
            lo <= quoFinal;
        end
    end

    assign mdDone   = moveDone || divDone || mulValid[mulStages-1];
    assign mdResult = moveDone ? moveResult : 32'h0;  // Only MFHI/MFLO return data
    assign mdBusy   = moveDone || divBusy || divDone || (|mulValid);

    aNoStartWhileBusy: assert property (@(posedge clk) disable iff (!rstN)
        mdStart |-> !mdBusy)
        else $error("mulDivUnit: mdStart while an operation is busy");

endmodule

// File: hw/resultMerge.sv
// Issue control and response register for the single in-flight execute request
`timescale 1ns/1ps

module resultMerge (
    input  logic              clk,
    input  logic              rstN,
    input  logic              reqValid,
    input  execPkg::execReqT  req,
    input  execPkg::aluOutT   aluOut,
    input  logic              mdDone,
    input  logic [31:0]       mdResult,
    input  logic              respReady,
    output logic              reqReady,
    output logic              mdStart,
    output logic              respValid,
    output execPkg::execRespT resp
);

    logic              inFlight;
    execPkg::unitE     flightUnit;
    execPkg::tagT      flightTag;
    execPkg::aluOutT   aluHold;
    logic              accept;
    logic              finish;
    execPkg::execRespT respNext;

    assign reqReady = !inFlight && !respValid;
    assign accept   = reqValid && reqReady;
    assign mdStart  = accept && (req.unit == execPkg::UNIT_MDU);
    assign finish   = inFlight && ((flightUnit == execPkg::UNIT_ALU) || mdDone);  // ALU takes one cycle

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            inFlight  <= 1'b0;
            respValid <= 1'b0;
        end
        else
        begin
            if (accept)
            begin
                inFlight <= 1'b1;
            end
            else if (finish)
            begin
                inFlight <= 1'b0;
            end
            if (finish)
            begin
                respValid <= 1'b1;
            end
            else if (respValid && respReady)
            begin
                respValid <= 1'b0;
            end
        end
    end

    always_comb
    begin
        respNext.tag = flightTag;
        if (flightUnit == execPkg::UNIT_ALU)
        begin
            respNext.result   = aluHold.result;
            respNext.excOccur = aluHold.excOccur;
            respNext.excCode  = aluHold.excCode;
        end
        else
        begin
            respNext.result   = mdResult;
            respNext.excOccur = 1'b0;
            respNext.excCode  = execPkg::EXC_NONE;
        end
        respNext.zero = (respNext.result == 32'h0);
    end

    // ALU output sampled at accept since req may move on afterwards
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            flightUnit <= req.unit;
            flightTag  <= req.tag;
            aluHold    <= aluOut;
        end
        if (finish)
        begin
            resp <= respNext;
        end
    end

    aRespStable: assert property (@(posedge clk) disable iff (!rstN)
        respValid && !respReady |=> respValid && $stable(resp))
        else $error("resultMerge: resp changed under back-pressure");

    aMdDoneInFlight: assert property (@(posedge clk) disable iff (!rstN)
        mdDone |-> inFlight && (flightUnit == execPkg::UNIT_MDU))
        else $error("resultMerge: mdDone without an MDU request in flight");

endmodule

// File: hw/execUnit.sv
// Execute stage top: ALU and multiply/divide unit joined by the result merger
`timescale 1ns/1ps

module execUnit #(
    parameter int mulStages = 2
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              reqValid,
    output logic              reqReady,
    input  execPkg::execReqT  req,
    output logic              respValid,
    input  logic              respReady,
    output execPkg::execRespT resp
);

    execPkg::aluOutT aluOut;
    logic            mdStart;
    logic            mdDone;
    logic [31:0]     mdResult;

    aluCore i_aluCore (
        .req    (req),
        .aluOut (aluOut)
    );

    mulDivUnit #(
        .mulStages (mulStages)
    ) i_mulDivUnit (
        .clk      (clk),
        .rstN     (rstN),
        .mdStart  (mdStart),
        .req      (req),
        .mdDone   (mdDone),
        .mdResult (mdResult)
    );

    resultMerge i_resultMerge (
        .clk       (clk),
        .rstN      (rstN),
        .reqValid  (reqValid),
        .req       (req),
        .aluOut    (aluOut),
        .mdDone    (mdDone),
        .mdResult  (mdResult),
        .respReady (respReady),
        .reqReady  (reqReady),
        .mdStart   (mdStart),
        .respValid (respValid),
        .resp      (resp)
    );

endmodule

// File: verification/execUnitTb.sv
// Directed testbench for the execute stage covering ALU, multiply/divide and handshakes
`timescale 1ns/1ps

module execUnitTb;

    localparam int mulStages  = 2;
    localparam int cycleLimit = 8000;  // About 150 ops at 36 cycles worst case, plus margin

    logic              clk;
    logic              rstN;
    logic              reqValid;
    logic              reqReady;
    execPkg::execReqT  req;
    logic              respValid;
    logic              respReady;
    execPkg::execRespT resp;

    integer            seed;
    int                cycleCount;
    execPkg::tagT      tagCount;
    logic [31:0]       hiModel;
    logic [31:0]       loModel;

    execUnit #(
        .mulStages (mulStages)
    ) i_dut (
        .clk       (clk),
        .rstN      (rstN),
        .reqValid  (reqValid),
        .reqReady  (reqReady),
        .req       (req),
        .respValid (respValid),
        .respReady (respReady),
        .resp      (resp)
    );

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit)
        begin
            $display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
            stopWithFail();
        end
    end

    task automatic stopWithFail();
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic checkResp(input execPkg::execRespT exp, input execPkg::execRespT act);
        if (act.tag !== exp.tag)
        begin
            $display("Fail resp.tag: expected 0x%0h, got 0x%0h", exp.tag, act.tag);
            stopWithFail();
        end
        if (act.result !== exp.result)
        begin
            $display("Fail resp.result: expected 0x%08h, got 0x%08h", exp.result, act.result);
            stopWithFail();
        end
        if (act.zero !== exp.zero)
        begin
            $display("Fail resp.zero: expected 0x%0h, got 0x%0h", exp.zero, act.zero);
            stopWithFail();
        end
        if (act.excOccur !== exp.excOccur)
        begin
            $display("Fail resp.excOccur: expected 0x%0h, got 0x%0h", exp.excOccur, act.excOccur);
            stopWithFail();
        end
        if (act.excCode !== exp.excCode)
        begin
            $display("Fail resp.excCode: expected 0x%0h, got 0x%0h", exp.excCode, act.excCode);
            stopWithFail();
        end
    endtask

    task automatic checkCycles(input int exp, input int act);
        if (act != exp)
        begin
            $display("Fail latency: expected 0x%0h, got 0x%0h", exp, act);
            stopWithFail();
        end
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("Fail %s: expected 0x%0h, got 0x%0h", name, exp, act);
            stopWithFail();
        end
    endtask

    function automatic logic [31:0] randWord();
        return $random(seed);
    endfunction

    function automatic int stallLength();
        return 1 + ({$random(seed)} % 8);
    endfunction

    function automatic logic [31:0] countLead(logic [31:0] v, logic bitVal);
        int n;
        n = 0;
        for (int i = 31; i >= 0; i--)
        begin
            if (v[i] !== bitVal)
            begin
                break;
            end
            n++;
        end
        return n;
    endfunction

    function automatic execPkg::execRespT buildResp(execPkg::tagT tag, logic [31:0] result,
                                                    logic ov);
        execPkg::execRespT r;
        r.tag      = tag;
        r.result   = result;
        r.zero     = (result == 32'h0);
        r.excOccur = ov;
        r.excCode  = ov ? execPkg::EXC_OV : execPkg::EXC_NONE;
        return r;
    endfunction

    function automatic execPkg::execRespT aluExpect(execPkg::aluOpE op, logic [31:0] a,
                                                    logic [31:0] b, execPkg::tagT tag);
        longint      sa;
        longint      sb;
        longint      wide;
        logic [31:0] r;
        logic        ov;
        sa = $signed(a);
        sb = $signed(b);
        ov = 1'b0;
        case (op)
            execPkg::ALU_ADD,
            execPkg::ALU_ADDU: wide = sa + sb;
            execPkg::ALU_SUB,
            execPkg::ALU_SUBU: wide = sa - sb;
            execPkg::ALU_SRA:  wide = sb >>> a[4:0];
            default:           wide = 0;
        endcase
        case (op)
            execPkg::ALU_AND:  r = a & b;
            execPkg::ALU_OR:   r = a | b;
            execPkg::ALU_XOR:  r = a ^ b;
            execPkg::ALU_NOR:  r = ~(a | b);
            execPkg::ALU_SLL:  r = b << a[4:0];
            execPkg::ALU_SRL:  r = b >> a[4:0];
            execPkg::ALU_LUI:  r = {b[15:0], 16'h0};
            execPkg::ALU_SLT:  r = (sa < sb) ? 32'd1 : 32'd0;
            execPkg::ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            execPkg::ALU_CLO:  r = countLead(a, 1'b1);
            execPkg::ALU_CLZ:  r = countLead(a, 1'b0);
            default:           r = wide[31:0];
        endcase
        // Trap when the exact value does not survive the wrap to 32 bits
        if (op == execPkg::ALU_ADD || op == execPkg::ALU_SUB)
        begin
            ov = (wide != longint'($signed(r)));
        end
        return buildResp(tag, r, ov);
    endfunction

    function automatic logic [31:0] mdUpdate(execPkg::mdOpE op, logic [31:0] a, logic [31:0] b);
        longint      sa;
        longint      sb;
        longint      quo;
        longint      rem;
        logic [63:0] prod;
        logic [31:0] r;
        sa = $signed(a);
        sb = $signed(b);
        r  = 32'h0;
        case (op)
            execPkg::MD_MULT,
            execPkg::MD_MULTU:
            begin
                prod = (op == execPkg::MD_MULT) ? sa * sb : {32'h0, a} * {32'h0, b};
                {hiModel, loModel} = prod;
            end
            execPkg::MD_DIV,
            execPkg::MD_DIVU:
            begin
                if (b == 32'h0)
                begin
                    hiModel = a;
                    loModel = 32'hffff_ffff;
                end
                else if (op == execPkg::MD_DIV)
                begin
                    quo     = sa / sb;  // Truncates toward zero
                    rem     = sa % sb;
                    hiModel = rem[31:0];
                    loModel = quo[31:0];
                end
                else
                begin
                    hiModel = a % b;
                    loModel = a / b;
                end
            end
            execPkg::MD_MFHI: r = hiModel;
            execPkg::MD_MFLO: r = loModel;
            execPkg::MD_MTHI: hiModel = a;
            default:          loModel = a;
        endcase
        return r;
    endfunction

    function automatic int mdLatency(execPkg::mdOpE op);
        case (op)
            execPkg::MD_MULT,
            execPkg::MD_MULTU: return mulStages;
            execPkg::MD_DIV,
            execPkg::MD_DIVU:  return 33;
            default:           return 1;
        endcase
    endfunction

    function automatic execPkg::execReqT makeReq(execPkg::unitE unit, execPkg::aluOpE aluOp,
                                                 execPkg::mdOpE mdOp, logic [31:0] a,
                                                 logic [31:0] b);
        execPkg::execReqT r;
        r.unit  = unit;
        r.aluOp = aluOp;
        r.mdOp  = mdOp;
        r.tag   = tagCount;
        r.srcA  = a;
        r.srcB  = b;
        return r;
    endfunction

    task automatic send(input execPkg::execReqT r, input execPkg::execRespT exp,
                        input int expCycles, input int stall);
        int                cycles;
        execPkg::execRespT held;
        logic [95:0]       noise;
        @(negedge clk);
        req      = r;
        reqValid = 1'b1;
        while (!reqReady)
        begin
            @(negedge clk);
        end
        @(posedge clk);  // Accepted here
        @(negedge clk);
        reqValid = 1'b0;
        cycles   = 0;
        while (!respValid)
        begin
            @(negedge clk);
            cycles++;
        end
        held = resp;
        checkResp(exp, held);
        checkCycles(expCycles, cycles);
        for (int i = 0; i < stall; i++)
        begin
            noise    = {randWord(), randWord(), randWord()};
            req      = noise[75:0];  // Competing request that must be held off
            reqValid = 1'b1;
            @(negedge clk);
            checkFlag("respValid", 1'b1, respValid);
            checkFlag("reqReady", 1'b0, reqReady);
            checkResp(held, resp);
        end
        reqValid  = 1'b0;
        respReady = 1'b1;
        @(posedge clk);
        @(negedge clk);
        respReady = 1'b0;
        checkFlag("respValid", 1'b0, respValid);
        checkFlag("reqReady", 1'b1, reqReady);
    endtask

    task automatic runAlu(input execPkg::aluOpE op, input logic [31:0] a, input logic [31:0] b,
                          input int stall);
        execPkg::execReqT r;
        r = makeReq(execPkg::UNIT_ALU, op, execPkg::MD_MULT, a, b);
        send(r, aluExpect(op, a, b, r.tag), 1, stall);
        tagCount = tagCount + 4'd1;
    endtask

    task automatic runMd(input execPkg::mdOpE op, input logic [31:0] a, input logic [31:0] b,
                         input int stall);
        execPkg::execReqT  r;
        execPkg::execRespT exp;
        r   = makeReq(execPkg::UNIT_MDU, execPkg::ALU_ADD, op, a, b);
        exp = buildResp(r.tag, mdUpdate(op, a, b), 1'b0);
        send(r, exp, mdLatency(op), stall);
        tagCount = tagCount + 4'd1;
    endtask

    task automatic testLogic();
        logic [31:0] opA [4];
        logic [31:0] opB [4];
        opA[0] = 32'h0000_0000;
        opB[0] = 32'hffff_ffff;
        opA[1] = 32'h8000_001f;  // Negative, shift by 31
        opB[1] = 32'h7fff_8000;
        opA[2] = randWord();
        opB[2] = randWord();
        opA[3] = randWord();
        opB[3] = randWord();
        for (int k = execPkg::ALU_AND; k <= execPkg::ALU_SLTU; k++)
        begin
            for (int i = 0; i < 4; i++)
            begin
                runAlu(execPkg::aluOpE'(k), opA[i], opB[i], 0);
            end
        end
    endtask

    task automatic testOverflow();
        logic [31:0] opA [4];
        logic [31:0] opB [4];
        opA[0] = 32'h7fff_ffff;
        opB[0] = 32'h0000_0001;
        opA[1] = 32'h8000_0000;
        opB[1] = 32'hffff_ffff;
        opA[2] = 32'h8000_0000;
        opB[2] = 32'h0000_0001;
        opA[3] = 32'h7fff_ffff;
        opB[3] = 32'hffff_ffff;
        for (int i = 0; i < 4; i++)
        begin
            for (int k = execPkg::ALU_ADD; k <= execPkg::ALU_SUBU; k++)
            begin
                runAlu(execPkg::aluOpE'(k), opA[i], opB[i], 0);
            end
        end
    endtask

    task automatic testCounts();
        logic [31:0] vals [8];
        vals[0] = 32'h0000_0000;
        vals[1] = 32'hffff_ffff;
        vals[2] = 32'h0000_0001;
        vals[3] = 32'h8000_0000;
        vals[4] = 32'h0001_0000;
        vals[5] = 32'hfffe_0000;
        vals[6] = randWord();
        vals[7] = randWord();
        for (int i = 0; i < 8; i++)
        begin
            runAlu(execPkg::ALU_CLO, vals[i], randWord(), 0);
            runAlu(execPkg::ALU_CLZ, vals[i], randWord(), 0);
        end
    endtask

    task automatic testMulDiv();
        logic [31:0] opA [4];
        logic [31:0] opB [4];
        opA[0] = randWord();
        opB[0] = randWord();
        opA[1] = 32'hffff_fff9;
        opB[1] = 32'h0000_0002;
        opA[2] = 32'h0000_0064;
        opB[2] = 32'hffff_fffd;
        opA[3] = randWord();
        opB[3] = 32'h0000_0000;  // Divide by zero
        for (int i = 0; i < 4; i++)
        begin
            for (int k = execPkg::MD_MULT; k <= execPkg::MD_DIVU; k++)
            begin
                runMd(execPkg::mdOpE'(k), opA[i], opB[i], 0);
                runMd(execPkg::MD_MFHI, 32'h0, 32'h0, 0);
                runMd(execPkg::MD_MFLO, 32'h0, 32'h0, 0);
            end
        end
    endtask

    task automatic testMoves();
        logic [31:0] hiVal;
        logic [31:0] loVal;
        for (int i = 0; i < 3; i++)
        begin
            hiVal = (i == 1) ? 32'h0 : randWord();
            loVal = (i == 2) ? 32'h0 : randWord();
            runMd(execPkg::MD_MTHI, hiVal, randWord(), 0);
            runMd(execPkg::MD_MTLO, loVal, randWord(), 0);
            runMd(execPkg::MD_MFLO, 32'h0, 32'h0, 0);
            runMd(execPkg::MD_MFHI, 32'h0, 32'h0, 0);
        end
    endtask

    task automatic testBackPressure();
        runAlu(execPkg::ALU_XOR, randWord(), randWord(), stallLength());
        runMd(execPkg::MD_MULT, randWord(), randWord(), stallLength());
        runMd(execPkg::MD_MFLO, 32'h0, 32'h0, stallLength());
        runMd(execPkg::MD_DIV, randWord(), 32'h0000_0007, stallLength());
        runMd(execPkg::MD_MFHI, 32'h0, 32'h0, stallLength());
    endtask

    initial
    begin
        clk        = 1'b0;
        rstN       = 1'b0;
        reqValid   = 1'b0;
        respReady  = 1'b0;
        req        = '0;
        seed       = 32'hd8d8;
        cycleCount = 0;
        tagCount   = '0;
        hiModel    = 32'h0;
        loModel    = 32'h0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        checkFlag("reqReady", 1'b1, reqReady);
        checkFlag("respValid", 1'b0, respValid);
        testLogic();
        testOverflow();
        testCounts();
        testMulDiv();
        testMoves();
        testBackPressure();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: flist.f
hw/execPkg.sv
hw/aluCore.sv
hw/mulDivUnit.sv
hw/resultMerge.sv
hw/execUnit.sv
verification/execUnitTb.sv
